// File: hw/trig_pkg.sv
package trig_pkg;

    // adc word layout.
    localparam int ADC_RESOLUTION_WIDTH = 12;
    localparam int SAMPLE_WIDTH = 16;
    localparam int SAMPLE_NUM_PER_CLK = 8;

    // low-gain path uses lanes 0 to 3 only.
    localparam int LGAIN_SAMPLE_NUM_PER_CLK = 4;
    localparam int LGAIN_SHIFT = 3; // gain ratio of 8.

    localparam int RFDC_TDATA_WIDTH = SAMPLE_WIDTH * SAMPLE_NUM_PER_CLK;
    localparam int LGAIN_TDATA_WIDTH = SAMPLE_WIDTH * LGAIN_SAMPLE_NUM_PER_CLK;

    // raw sample sits in the top bits of each lane.
    localparam int RAW_LSB = SAMPLE_WIDTH - ADC_RESOLUTION_WIDTH;

    localparam logic signed [ADC_RESOLUTION_WIDTH:0] H_BASELINE_DEFAULT = -13'sd1024;
    localparam logic signed [SAMPLE_WIDTH-1:0] L_BASELINE_DEFAULT = 16'sd128;
    localparam logic signed [SAMPLE_WIDTH-1:0] THRESHOLD_DEFAULT = 16'sd512;

    // matches the trigger latency.
    localparam int DELAY_DEPTH = 1;

    localparam int BEAT_COUNT_WIDTH = 16;
    localparam int LANE_WIDTH = $clog2(SAMPLE_NUM_PER_CLK);

    // input, high-gain and dsp streams.
    typedef struct packed {
        logic [RFDC_TDATA_WIDTH-1:0] tdata;
        logic                        tvalid;
    } rfdc_beat_t;

    typedef struct packed {
        logic [LGAIN_TDATA_WIDTH-1:0] tdata;
        logic                         tvalid;
    } lgain_beat_t;

    // one event per excursion above threshold.
    typedef struct packed {
        logic                        fire;
        logic [LANE_WIDTH-1:0]       lane;
        logic [BEAT_COUNT_WIDTH-1:0] beat_count;
    } trig_event_t;

endpackage

// File: hw/dummy_signal_generator.sv
`timescale 1ns/100ps

module dummy_signal_generator (
    input  logic                                             ACLK,
    input  logic                                             ARESET,
    input  logic                                             set_config,
    input  logic signed [trig_pkg::ADC_RESOLUTION_WIDTH:0]   h_gain_baseline_in,
    input  logic signed [trig_pkg::SAMPLE_WIDTH-1:0]         l_gain_baseline_in,
    input  trig_pkg::rfdc_beat_t                             s_axis,
    output logic                                             s_axis_tready,
    output trig_pkg::rfdc_beat_t                             h_beat,
    output trig_pkg::lgain_beat_t                            l_beat,
    output trig_pkg::rfdc_beat_t                             dsp_beat
);

    logic signed [trig_pkg::ADC_RESOLUTION_WIDTH:0] h_baseline_r;
    logic signed [trig_pkg::ADC_RESOLUTION_WIDTH:0] h_baseline_nxt;
    logic signed [trig_pkg::SAMPLE_WIDTH-1:0]       l_baseline_sel;

    logic signed [trig_pkg::ADC_RESOLUTION_WIDTH-1:0] raw [trig_pkg::SAMPLE_NUM_PER_CLK];
    logic signed [trig_pkg::ADC_RESOLUTION_WIDTH:0]   diff [trig_pkg::SAMPLE_NUM_PER_CLK];

    logic [trig_pkg::RFDC_TDATA_WIDTH-1:0]  dsp_tdata;
    logic [trig_pkg::LGAIN_TDATA_WIDTH-1:0] l_tdata;
    logic [trig_pkg::RFDC_TDATA_WIDTH-1:0]  h_idle;
    logic [trig_pkg::LGAIN_TDATA_WIDTH-1:0] l_idle;

    logic clear;

    assign clear = ARESET || set_config;

    // idle patterns follow the baseline being loaded this cycle.
    always_comb begin
        if (ARESET) begin
            h_baseline_nxt = trig_pkg::H_BASELINE_DEFAULT;
        end else if (set_config) begin
            h_baseline_nxt = h_gain_baseline_in;
        end else begin
            h_baseline_nxt = h_baseline_r;
        end
    end

    assign l_baseline_sel = ARESET ? trig_pkg::L_BASELINE_DEFAULT : l_gain_baseline_in;

    always_ff @(posedge ACLK) begin
        h_baseline_r <= h_baseline_nxt;
    end

    always_comb begin
        for (int i = 0; i < trig_pkg::SAMPLE_NUM_PER_CLK; i++) begin
            raw[i] = s_axis.tdata[i*trig_pkg::SAMPLE_WIDTH + trig_pkg::RAW_LSB
                                  +: trig_pkg::ADC_RESOLUTION_WIDTH];
            diff[i] = {raw[i][trig_pkg::ADC_RESOLUTION_WIDTH-1], raw[i]} - h_baseline_r;
            dsp_tdata[i*trig_pkg::SAMPLE_WIDTH +: trig_pkg::SAMPLE_WIDTH] =
                {{(trig_pkg::RAW_LSB-1){diff[i][trig_pkg::ADC_RESOLUTION_WIDTH]}}, diff[i]};
            // sign bit, bits 10..0, zero pad.
            h_idle[i*trig_pkg::SAMPLE_WIDTH +: trig_pkg::SAMPLE_WIDTH] =
                {h_baseline_nxt[trig_pkg::ADC_RESOLUTION_WIDTH],
                 h_baseline_nxt[trig_pkg::ADC_RESOLUTION_WIDTH-2:0],
                 {trig_pkg::RAW_LSB{1'b0}}};
        end
        for (int i = 0; i < trig_pkg::LGAIN_SAMPLE_NUM_PER_CLK; i++) begin
            l_tdata[i*trig_pkg::SAMPLE_WIDTH +: trig_pkg::SAMPLE_WIDTH] =
                {{trig_pkg::RAW_LSB{raw[i][trig_pkg::ADC_RESOLUTION_WIDTH-1]}},
                 raw[i] >>> trig_pkg::LGAIN_SHIFT};
            l_idle[i*trig_pkg::SAMPLE_WIDTH +: trig_pkg::SAMPLE_WIDTH] = l_baseline_sel;
        end
    end

    always_ff @(posedge ACLK) begin
        if (clear) begin
            s_axis_tready <= 1'b0;
        end else begin
            s_axis_tready <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (clear) begin
            h_beat.tdata   <= h_idle;
            h_beat.tvalid  <= 1'b0;
            l_beat.tdata   <= l_idle;
            l_beat.tvalid  <= 1'b0;
            dsp_beat.tdata <= '0;
            dsp_beat.tvalid <= 1'b0;
        end else begin
            h_beat.tdata   <= s_axis.tdata; // passthrough.
            l_beat.tdata   <= l_tdata;
            dsp_beat.tdata <= dsp_tdata;
            // beats offered while not ready are dropped.
            h_beat.tvalid   <= s_axis.tvalid && s_axis_tready;
            l_beat.tvalid   <= s_axis.tvalid && s_axis_tready;
            dsp_beat.tvalid <= s_axis.tvalid && s_axis_tready;
        end
    end

endmodule

// File: hw/stream_delay_line.sv
`timescale 1ns/100ps

module stream_delay_line #(
    parameter type payload_t = trig_pkg::rfdc_beat_t,
    parameter int  DEPTH     = trig_pkg::DELAY_DEPTH
) (
    input  logic     ACLK,
    input  logic     ARESET,
    input  payload_t in_beat,
    output payload_t out_beat
);

    payload_t stage [DEPTH];

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0; // tvalid low out of reset.
            end
        end else begin
            stage[0] <= in_beat;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out_beat = stage[DEPTH-1];

endmodule

// File: hw/sample_threshold_trigger.sv
`timescale 1ns/100ps

module sample_threshold_trigger (
    input  logic                                     ACLK,
    input  logic                                     ARESET,
    input  logic                                     set_config,
    input  logic signed [trig_pkg::SAMPLE_WIDTH-1:0] threshold_in,
    input  trig_pkg::rfdc_beat_t                     dsp_beat,
    output trig_pkg::trig_event_t                    trig_event
);

    logic signed [trig_pkg::SAMPLE_WIDTH-1:0]  threshold_r;
    logic [trig_pkg::SAMPLE_NUM_PER_CLK-1:0]   hit_mask;
    logic [trig_pkg::LANE_WIDTH-1:0]           first_lane;
    logic [trig_pkg::BEAT_COUNT_WIDTH-1:0]     beat_count;
    logic                                      armed;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            threshold_r <= trig_pkg::THRESHOLD_DEFAULT;
        end else if (set_config) begin
            threshold_r <= threshold_in;
        end
    end

    // signed per-lane compare for valid beats only.
    always_comb begin
        for (int i = 0; i < trig_pkg::SAMPLE_NUM_PER_CLK; i++) begin
            hit_mask[i] = dsp_beat.tvalid &&
                ($signed(dsp_beat.tdata[i*trig_pkg::SAMPLE_WIDTH +: trig_pkg::SAMPLE_WIDTH])
                 > threshold_r);
        end
    end

    // lowest hit lane wins.
    always_comb begin
        first_lane = '0;
        for (int i = trig_pkg::SAMPLE_NUM_PER_CLK - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                first_lane = i[trig_pkg::LANE_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            armed      <= 1'b1;
            beat_count <= '0;
            trig_event <= '0;
        end else begin
            trig_event <= '0; // single-cycle event.
            if (dsp_beat.tvalid) begin
                beat_count <= beat_count + 1'b1; // wraps.
                // an empty beat rearms and any hit disarms.
                armed <= ~|hit_mask;
                if (armed && |hit_mask) begin
                    trig_event.fire       <= 1'b1;
                    trig_event.lane       <= first_lane;
                    trig_event.beat_count <= beat_count;
                end
            end
        end
    end

endmodule

// File: hw/trigger_subsystem_top.sv
`timescale 1ns/100ps

module trigger_subsystem_top (
    input  logic                                           ACLK,
    input  logic                                           ARESET,
    input  trig_pkg::rfdc_beat_t                           s_axis,
    input  logic                                           set_config,
    input  logic signed [trig_pkg::ADC_RESOLUTION_WIDTH:0] h_gain_baseline,
    input  logic signed [trig_pkg::SAMPLE_WIDTH-1:0]       l_gain_baseline,
    input  logic signed [trig_pkg::SAMPLE_WIDTH-1:0]       threshold,
    output logic                                           s_axis_tready,
    output trig_pkg::rfdc_beat_t                           h_m_axis,
    output trig_pkg::lgain_beat_t                          l_m_axis,
    output trig_pkg::rfdc_beat_t                           dsp_m_axis,
    output trig_pkg::trig_event_t                          trig_event
);

    trig_pkg::rfdc_beat_t  gen_h_beat;
    trig_pkg::lgain_beat_t gen_l_beat;

    dummy_signal_generator u_gen (
        .ACLK               (ACLK),
        .ARESET             (ARESET),
        .set_config         (set_config),
        .h_gain_baseline_in (h_gain_baseline),
        .l_gain_baseline_in (l_gain_baseline),
        .s_axis             (s_axis),
        .s_axis_tready      (s_axis_tready),
        .h_beat             (gen_h_beat),
        .l_beat             (gen_l_beat),
        .dsp_beat           (dsp_m_axis)
    );

    // h and l wait out the trigger latency.
    stream_delay_line #(
        .payload_t (trig_pkg::rfdc_beat_t),
        .DEPTH     (trig_pkg::DELAY_DEPTH)
    ) u_h_delay (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .in_beat  (gen_h_beat),
        .out_beat (h_m_axis)
    );

    stream_delay_line #(
        .payload_t (trig_pkg::lgain_beat_t),
        .DEPTH     (trig_pkg::DELAY_DEPTH)
    ) u_l_delay (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .in_beat  (gen_l_beat),
        .out_beat (l_m_axis)
    );

    sample_threshold_trigger u_trig (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .set_config   (set_config),
        .threshold_in (threshold),
        .dsp_beat     (dsp_m_axis),
        .trig_event   (trig_event)
    );

endmodule

// File: test/trigger_subsystem_asserts.sv
`timescale 1ns/100ps

module trigger_subsystem_asserts (
    input logic                  ACLK,
    input logic                  ARESET,
    input trig_pkg::rfdc_beat_t  dsp_beat,
    input trig_pkg::trig_event_t trig_event
);

    // an event needs a valid dsp beat one cycle earlier.
    fire_after_valid: assert property (@(posedge ACLK) disable iff (ARESET)
        trig_event.fire |-> $past(dsp_beat.tvalid))
        else $error("fire without a valid dsp beat before it");

    // rearm takes at least one empty beat.
    no_double_fire: assert property (@(posedge ACLK) disable iff (ARESET)
        trig_event.fire |=> !trig_event.fire)
        else $error("fire held for two cycles");

    quiet_after_reset: assert property (@(posedge ACLK)
        ARESET |=> !trig_event.fire)
        else $error("fire set right after reset");

endmodule

bind sample_threshold_trigger trigger_subsystem_asserts u_asserts (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .dsp_beat   (dsp_beat),
    .trig_event (trig_event)
);

// File: test/trigger_subsystem_tb.sv
`timescale 1ns/100ps

module trigger_subsystem_tb;

    logic                  ACLK = 1'b0;
    logic                  ARESET;
    trig_pkg::rfdc_beat_t  s_axis;
    logic                  set_config;
    logic signed [12:0]    h_gain_baseline;
    logic signed [15:0]    l_gain_baseline;
    logic signed [15:0]    threshold;
    logic                  s_axis_tready;
    trig_pkg::rfdc_beat_t  h_m_axis;
    trig_pkg::lgain_beat_t l_m_axis;
    trig_pkg::rfdc_beat_t  dsp_m_axis;
    trig_pkg::trig_event_t trig_event;

    int mismatches = 0;
    int timeouts = 0;
    logic [15:0] lfsr_state = 16'd37;
    string cur_name = "reset";

    // stimulus table.
    string        row_name[$];
    bit           row_cfg[$];
    logic [12:0]  row_hb[$];
    logic [15:0]  row_lb[$];
    logic [15:0]  row_thr[$];
    bit           row_valid[$];
    bit           row_rnd[$];
    logic [127:0] row_data[$];

    // reference model state.
    logic                  m_ready;
    logic signed [12:0]    m_hbase;
    logic signed [15:0]    m_lbase;
    logic signed [15:0]    m_thr;
    trig_pkg::rfdc_beat_t  m_gen_h;
    trig_pkg::lgain_beat_t m_gen_l;
    trig_pkg::rfdc_beat_t  m_gen_dsp;
    trig_pkg::rfdc_beat_t  m_h_out;
    trig_pkg::lgain_beat_t m_l_out;
    trig_pkg::trig_event_t m_ev;
    logic                  m_armed;
    logic [15:0]           m_count;

    trigger_subsystem_top u_trigger_subsystem_top (.*);

    initial begin
        forever #4 ACLK = ~ACLK;
    end

    function automatic bit next_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    function automatic logic [127:0] random_word();
        logic [127:0] w;
        for (int i = 0; i < 128; i++) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    // raw value hi on the lanes in mask, lo elsewhere.
    function automatic logic [127:0] lanes_hot(logic [7:0] mask, int hi, int lo);
        logic [127:0] w;
        int v;
        for (int i = 0; i < 8; i++) begin
            v = mask[i] ? hi : lo;
            w[i*16 +: 16] = {v[11:0], 4'b0000};
        end
        return w;
    endfunction

    function automatic logic [127:0] h_idle(logic signed [12:0] base);
        logic [127:0] w;
        for (int i = 0; i < 8; i++) begin
            w[i*16 +: 16] = {base[12], base[10:0], 4'b0000};
        end
        return w;
    endfunction

    function automatic logic [15:0] dsp_lane(logic [15:0] word, logic signed [12:0] base);
        int raw;
        int d;
        logic [12:0] t;
        raw = $signed(word[15:4]);
        d = raw - int'(base);
        t = d[12:0]; // wraps at 13 bits.
        return {{3{t[12]}}, t};
    endfunction

    function automatic logic [15:0] l_lane(logic [15:0] word);
        int raw;
        raw = $signed(word[15:4]);
        raw = raw >>> 3;
        return raw[15:0];
    endfunction

    task automatic add_row(string name, bit cfg, logic [12:0] hb, logic [15:0] lb,
                           logic [15:0] thr, bit valid, bit rnd, logic [127:0] data);
        row_name.push_back(name);
        row_cfg.push_back(cfg);
        row_hb.push_back(hb);
        row_lb.push_back(lb);
        row_thr.push_back(thr);
        row_valid.push_back(valid);
        row_rnd.push_back(rnd);
        row_data.push_back(data);
    endtask

    // model of one rising edge with the inputs now applied.
    task automatic model_step();
        logic [7:0] mask;
        logic [2:0] first;
        m_h_out = m_gen_h;
        m_l_out = m_gen_l;
        m_ev = '0;
        if (set_config) begin
            m_armed = 1'b1;
            m_count = '0;
            m_thr = threshold;
        end else if (m_gen_dsp.tvalid) begin
            first = '0;
            for (int i = 7; i >= 0; i--) begin
                mask[i] = $signed(m_gen_dsp.tdata[i*16 +: 16]) > m_thr;
                if (mask[i]) first = i[2:0];
            end
            if (m_armed && mask != 0) begin
                m_ev.fire = 1'b1;
                m_ev.lane = first;
                m_ev.beat_count = m_count;
            end
            m_armed = (mask == 0);
            m_count = m_count + 16'd1;
        end
        if (set_config) begin
            m_hbase = h_gain_baseline;
            m_lbase = l_gain_baseline;
            m_gen_h = '{tdata: h_idle(m_hbase), tvalid: 1'b0};
            m_gen_l = '{tdata: {4{m_lbase}}, tvalid: 1'b0};
            m_gen_dsp = '0;
        end else begin
            m_gen_h.tdata = s_axis.tdata;
            m_gen_h.tvalid = s_axis.tvalid && m_ready;
            m_gen_l.tvalid = m_gen_h.tvalid;
            m_gen_dsp.tvalid = m_gen_h.tvalid;
            for (int i = 0; i < 8; i++) begin
                m_gen_dsp.tdata[i*16 +: 16] = dsp_lane(s_axis.tdata[i*16 +: 16], m_hbase);
            end
            for (int i = 0; i < 4; i++) begin
                m_gen_l.tdata[i*16 +: 16] = l_lane(s_axis.tdata[i*16 +: 16]);
            end
        end
        m_ready = !set_config;
    endtask

    task automatic check_val(string what, logic [128:0] exp, logic [128:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s.%s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    // model the coming edge and compare at the next falling edge.
    task automatic step_and_check();
        model_step();
        @(negedge ACLK);
        check_val("tready", 129'(m_ready), 129'(s_axis_tready));
        check_val("dsp", m_gen_dsp, dsp_m_axis);
        check_val("h", m_h_out, h_m_axis);
        check_val("l", 129'(m_l_out), 129'(l_m_axis));
        check_val("event", 129'(m_ev), 129'(trig_event));
    endtask

    task automatic drive_idle();
        set_config = 1'b0;
        s_axis = '0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!s_axis_tready && n < 20) begin
            drive_idle();
            step_and_check();
            n++;
        end
        assert (s_axis_tready) else begin
            timeouts++;
            $display("Timeout: s_axis_tready never went high in %s", cur_name);
        end
    endtask

    initial begin
        ARESET = 1'b1;
        s_axis = '0;
        set_config = 1'b0;
        h_gain_baseline = '0;
        l_gain_baseline = '0;
        threshold = '0;

        for (int i = 0; i < 6; i++) add_row("random", 0, 0, 0, 0, 1, 1, '0);
        add_row("invalid", 0, 0, 0, 0, 0, 1, '0);
        add_row("invalid", 0, 0, 0, 0, 0, 1, '0);
        add_row("reconfig", 1, 13'd0, -16'sd5, 16'sd100, 0, 0, '0);
        for (int i = 0; i < 3; i++) add_row("random_new_base", 0, 0, 0, 0, 1, 1, '0);
        add_row("empty", 0, 0, 0, 0, 1, 0, lanes_hot(8'h00, 200, 0));
        add_row("lane5", 0, 0, 0, 0, 1, 0, lanes_hot(8'h20, 200, 0));
        add_row("lane5_again", 0, 0, 0, 0, 1, 0, lanes_hot(8'h20, 200, 0));
        add_row("invalid_cross", 0, 0, 0, 0, 0, 0, lanes_hot(8'h44, 200, 0));
        add_row("empty_rearm", 0, 0, 0, 0, 1, 0, lanes_hot(8'h00, 200, -50));
        add_row("invalid_cross", 0, 0, 0, 0, 0, 0, lanes_hot(8'h44, 200, 0));
        add_row("lanes_2_6", 0, 0, 0, 0, 1, 0, lanes_hot(8'h44, 150, 0));
        for (int i = 0; i < 3; i++) add_row("drain", 0, 0, 0, 0, 0, 0, '0);

        repeat (3) @(negedge ACLK);
        m_ready = 1'b0;
        m_hbase = trig_pkg::H_BASELINE_DEFAULT;
        m_lbase = trig_pkg::L_BASELINE_DEFAULT;
        m_thr = trig_pkg::THRESHOLD_DEFAULT;
        m_gen_h = '{tdata: h_idle(m_hbase), tvalid: 1'b0};
        m_gen_l = '{tdata: {4{m_lbase}}, tvalid: 1'b0};
        m_gen_dsp = '0;
        m_h_out = '0;
        m_l_out = '0;
        m_ev = '0;
        m_armed = 1'b1;
        m_count = '0;
        ARESET = 1'b0;
        wait_ready();

        for (int r = 0; r < row_name.size(); r++) begin
            cur_name = row_name[r];
            if (row_valid[r]) wait_ready();
            set_config = row_cfg[r];
            h_gain_baseline = row_hb[r];
            l_gain_baseline = row_lb[r];
            threshold = row_thr[r];
            s_axis.tvalid = row_valid[r];
            s_axis.tdata = row_rnd[r] ? random_word() : row_data[r];
            step_and_check();
        end

        $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: trigger_subsystem_top.f
hw/trig_pkg.sv
hw/dummy_signal_generator.sv
hw/stream_delay_line.sv
hw/sample_threshold_trigger.sv
hw/trigger_subsystem_top.sv
test/trigger_subsystem_asserts.sv
test/trigger_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall --top-module trigger_subsystem_tb \
    -f trigger_subsystem_top.f -o sim_trigger_subsystem

status=0
./obj_dir/sim_trigger_subsystem > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Verification failed" sim.log \
    || ! grep -q "Verification passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
